/* mm_pkg.sv */
// Shared types for the integer matrix-vector MAC accelerator.
// Elements are signed 8-bit, accumulators signed 20-bit. The widths are
// chosen so that a full ARRAY_DIM reduction plus bias cannot overflow.
// IDX_W must be wide enough to index ARRAY_DIM rows.

package mm_pkg;

  localparam int DATA_W    = 8;
  localparam int ACC_W     = 20;
  localparam int ARRAY_DIM = 4;
  localparam int IDX_W     = 2;

  // Scalar element and accumulator
  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // One X row, the W vector or the Y vector
  typedef elem_t [ARRAY_DIM-1:0] elem_vec_t;

  // Finished result, one accumulator per row
  typedef acc_t [ARRAY_DIM-1:0] z_vec_t;

  // Tag carried with every input beat
  typedef enum logic [1:0] {
    BEAT_X_ROW = 2'd0,
    BEAT_W_VEC = 2'd1,
    BEAT_Y_VEC = 2'd2
  } beat_kind_e;

  // Row is only looked at for X row beats
  typedef struct packed {
    beat_kind_e       kind;
    logic [IDX_W-1:0] row;
    elem_vec_t        data;
  } in_beat_t;

  // Complete operand set for one job
  typedef struct packed {
    elem_vec_t [ARRAY_DIM-1:0] x;
    elem_vec_t                 w;
    elem_vec_t                 y;
  } job_t;

endpackage

/* mm_load_buffer.sv */
// Collects tagged input beats into one operand set.
// A beat overwrites the slot it names, so the last write wins.
// Beats are refused while the accelerator is busy and while a complete
// set waits for its start pulse. A beat kind outside the enum is dropped.
`timescale 1ns/10ps

module mm_load_buffer
  import mm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  in_beat_t in_beat_i,
  output logic     in_ready_o,
  input  logic     busy_i,
  output job_t     job_o,
  output logic     job_start_o
);

  job_t                 job_q;
  logic [ARRAY_DIM-1:0] x_written_q;
  logic                 w_written_q;
  logic                 y_written_q;
  logic                 all_written;
  logic                 accept;
  logic                 job_start_q;

  assign all_written = (&x_written_q) & w_written_q & y_written_q;

  // Hold off new beats until the engine has taken the set
  assign in_ready_o = !busy_i && !all_written;
  assign accept     = in_valid_i && in_ready_o;

  // Written flags and the start pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_written_q <= '0;
      w_written_q <= 1'b0;
      y_written_q <= 1'b0;
      job_start_q <= 1'b0;
    end else begin
      job_start_q <= all_written;
      if (all_written) begin
        x_written_q <= '0;
        w_written_q <= 1'b0;
        y_written_q <= 1'b0;
      end else if (accept) begin
        case (in_beat_i.kind)
          BEAT_X_ROW: x_written_q[in_beat_i.row] <= 1'b1;
          BEAT_W_VEC: w_written_q <= 1'b1;
          BEAT_Y_VEC: y_written_q <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Operand storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      case (in_beat_i.kind)
        BEAT_X_ROW: job_q.x[in_beat_i.row] <= in_beat_i.data;
        BEAT_W_VEC: job_q.w <= in_beat_i.data;
        BEAT_Y_VEC: job_q.y <= in_beat_i.data;
        default: ;
      endcase
    end
  end

  assign job_o       = job_q;
  assign job_start_o = job_start_q;

endmodule

/* mm_pe_row.sv */
// One row of the array: multiplies X[r][k] by W[k] and accumulates.
// NumPipeRegs sets the product pipeline depth, valid from 1 to 3.
// y_i must stay stable until the last product has been accumulated.
`timescale 1ns/10ps

module mm_pe_row
  import mm_pkg::*;
#(
  parameter int NumPipeRegs = 1
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  elem_t x_i,
  input  elem_t w_i,
  input  elem_t y_i,
  input  logic  issue_i,
  input  logic  first_i,
  output acc_t  acc_o
);

  localparam int ProdW = 2 * DATA_W;

  logic signed [ProdW-1:0] prod_q [NumPipeRegs];
  logic [NumPipeRegs-1:0]  vld_q;
  logic [NumPipeRegs-1:0]  first_q;
  acc_t                    acc_q;

  // Valid and first markers travel alongside the product
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q   <= '0;
      first_q <= '0;
    end else begin
      vld_q[0]   <= issue_i;
      first_q[0] <= first_i;
      for (int i = 1; i < NumPipeRegs; i++) begin
        vld_q[i]   <= vld_q[i-1];
        first_q[i] <= first_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    prod_q[0] <= x_i * w_i;
    for (int i = 1; i < NumPipeRegs; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
    // First product of a job starts from the bias
    if (vld_q[NumPipeRegs-1]) begin
      if (first_q[NumPipeRegs-1]) begin
        acc_q <= acc_t'(y_i) + acc_t'(prod_q[NumPipeRegs-1]);
      end else begin
        acc_q <= acc_q + acc_t'(prod_q[NumPipeRegs-1]);
      end
    end
  end

  assign acc_o = acc_q;

endmodule

/* mm_engine.sv */
// Steps the reduction index over ARRAY_DIM cycles and feeds all rows.
// z_done_o fires ARRAY_DIM + NumPipeRegs + 1 cycles after job_start_i.
// job_i must stay stable from job_start_i until z_done_o.
// A new job_start_i while a job is running restarts the issue.
`timescale 1ns/10ps

module mm_engine
  import mm_pkg::*;
#(
  parameter int NumPipeRegs = 1
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   job_start_i,
  input  job_t   job_i,
  output z_vec_t z_o,
  output logic   z_done_o
);

  logic [IDX_W-1:0]     k_q;
  logic                 issue_q;
  logic                 first_issue;
  logic                 last_issue;
  logic [NumPipeRegs:0] done_sr_q;

  assign first_issue = issue_q && (k_q == '0);
  assign last_issue  = issue_q && (k_q == IDX_W'(ARRAY_DIM - 1));

  // Reduction counter, one W element per cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_q <= 1'b0;
      k_q     <= '0;
    end else if (job_start_i) begin
      issue_q <= 1'b1;
      k_q     <= '0;
    end else if (issue_q) begin
      if (last_issue) begin
        issue_q <= 1'b0;
        k_q     <= '0;
      end else begin
        k_q <= k_q + 1'b1;
      end
    end
  end

  // Follows the last issue through the product pipe and accumulator
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_sr_q <= '0;
    end else begin
      done_sr_q <= {done_sr_q[NumPipeRegs-1:0], last_issue};
    end
  end

  assign z_done_o = done_sr_q[NumPipeRegs];

  for (genvar r = 0; r < ARRAY_DIM; r++) begin : gen_rows
    mm_pe_row #(
      .NumPipeRegs ( NumPipeRegs       )
    ) i_pe_row (
      .clk_i       ( clk_i             ),
      .rst_i       ( rst_i             ),
      .x_i         ( job_i.x[r][k_q]   ),
      .w_i         ( job_i.w[k_q]      ),
      .y_i         ( job_i.y[r]        ),
      .issue_i     ( issue_q           ),
      .first_i     ( first_issue       ),
      .acc_o       ( z_o[r]            )
    );
  end

endmodule

/* mm_z_buffer.sv */
// Holds the finished Z vector until the consumer accepts it.
// z_valid_o and z_o stay stable while z_ready_i is low.
// busy_o covers the whole job, from the start pulse to the hand-off,
// and is high already in the cycle of job_start_i.
`timescale 1ns/10ps

module mm_z_buffer
  import mm_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   job_start_i,
  input  logic   z_done_i,
  input  z_vec_t z_i,
  output logic   z_valid_o,
  output z_vec_t z_o,
  input  logic   z_ready_i,
  output logic   busy_o
);

  z_vec_t z_q;
  logic   z_valid_q;
  logic   busy_q;
  logic   handoff;

  assign handoff = z_valid_q && z_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      z_valid_q <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      if (z_done_i) begin
        z_valid_q <= 1'b1;
      end else if (handoff) begin
        z_valid_q <= 1'b0;
      end
      if (job_start_i) begin
        busy_q <= 1'b1;
      end else if (handoff) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (z_done_i) begin
      z_q <= z_i;
    end
  end

  assign z_valid_o = z_valid_q;
  assign z_o       = z_q;
  // Start pulse counts at once so no beat slips in before busy_q is set
  assign busy_o    = busy_q | job_start_i;

endmodule

/* mm_top.sv */
// Matrix-vector MAC accelerator, Z = Y + X * W on one ARRAY_DIM block.
// Input and output use valid/ready. Only one job runs at a time.
// NumPipeRegs is the product pipeline depth per row, from 1 to 3.
// First Z comes ARRAY_DIM + NumPipeRegs + 3 cycles after the last beat.
`timescale 1ns/10ps

module mm_top
  import mm_pkg::*;
#(
  parameter int NumPipeRegs = 1
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  in_beat_t in_beat_i,
  output logic     in_ready_o,
  output logic     z_valid_o,
  output z_vec_t   z_o,
  input  logic     z_ready_i,
  output logic     busy_o
);

  job_t   job;
  logic   job_start;
  z_vec_t z_engine;
  logic   z_done;

  mm_load_buffer i_load_buffer (
    .clk_i       ( clk_i      ),
    .rst_i       ( rst_i      ),
    .in_valid_i  ( in_valid_i ),
    .in_beat_i   ( in_beat_i  ),
    .in_ready_o  ( in_ready_o ),
    .busy_i      ( busy_o     ),
    .job_o       ( job        ),
    .job_start_o ( job_start  )
  );

  mm_engine #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_engine (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .job_start_i ( job_start   ),
    .job_i       ( job         ),
    .z_o         ( z_engine    ),
    .z_done_o    ( z_done      )
  );

  mm_z_buffer i_z_buffer (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .job_start_i ( job_start   ),
    .z_done_i    ( z_done      ),
    .z_i         ( z_engine    ),
    .z_valid_o   ( z_valid_o   ),
    .z_o         ( z_o         ),
    .z_ready_i   ( z_ready_i   ),
    .busy_o      ( busy_o      )
  );

endmodule

/* tb_mm.sv */
// Directed testbench for the matrix-vector MAC accelerator.
// Inputs are driven 10 ns after the rising edge and outputs are sampled
// at that same point, once all registers have settled.
// Runs with the default pipeline depth, so the job latency is 8 cycles.
`timescale 1ns/10ps

module tb_mm
  import mm_pkg::*;
();

  localparam int PipeRegs  = 1;
  localparam int WaitLimit = 50;
  // Cycles from the completing beat's edge to z_valid_o
  localparam int Latency   = ARRAY_DIM + PipeRegs + 3;

  logic     clk_i;
  logic     rst_i;
  logic     in_valid_i;
  in_beat_t in_beat_i;
  logic     in_ready_o;
  logic     z_valid_o;
  z_vec_t   z_o;
  logic     z_ready_i;
  logic     busy_o;

  logic [31:0]               lfsr_q = 32'h62a0_04db;
  // Model copy of the operands as last written
  elem_vec_t [ARRAY_DIM-1:0] x_m;
  elem_vec_t                 w_m;
  elem_vec_t                 y_m;

  mm_top #(
    .NumPipeRegs ( PipeRegs   )
  ) i_dut (
    .clk_i       ( clk_i      ),
    .rst_i       ( rst_i      ),
    .in_valid_i  ( in_valid_i ),
    .in_beat_i   ( in_beat_i  ),
    .in_ready_o  ( in_ready_o ),
    .z_valid_o   ( z_valid_o  ),
    .z_o         ( z_o        ),
    .z_ready_i   ( z_ready_i  ),
    .busy_o      ( busy_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic elem_vec_t rand_vec();
    elem_vec_t v;
    for (int i = 0; i < ARRAY_DIM * DATA_W; i++) begin
      v[i / DATA_W][i % DATA_W] = lfsr_bit();
    end
    return v;
  endfunction

  // Z[r] = Y[r] + sum over k of X[r][k] * W[k]
  function automatic z_vec_t expected_z(elem_vec_t [ARRAY_DIM-1:0] x, elem_vec_t w,
                                        elem_vec_t y);
    z_vec_t z;
    elem_t  xe;
    elem_t  we;
    elem_t  ye;
    int     sum;
    for (int r = 0; r < ARRAY_DIM; r++) begin
      ye  = y[r];
      sum = int'(ye);
      for (int k = 0; k < ARRAY_DIM; k++) begin
        xe  = x[r][k];
        we  = w[k];
        sum = sum + int'(xe) * int'(we);
      end
      z[r] = acc_t'(sum);
    end
    return z;
  endfunction

  task automatic check_z(input z_vec_t got, input z_vec_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, Z got %h expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Z vector mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Signal mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Gave up after %0d cycles waiting for %s", WaitLimit, what);
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  // Sends one beat, records it in the model and returns after the accept edge
  task automatic load_beat(input beat_kind_e kind, input logic [IDX_W-1:0] row,
                           input elem_vec_t data);
    int n;
    n = 0;
    case (kind)
      BEAT_X_ROW: x_m[row] = data;
      BEAT_W_VEC: w_m = data;
      default:    y_m = data;
    endcase
    in_beat_i.kind = kind;
    in_beat_i.row  = row;
    in_beat_i.data = data;
    in_valid_i     = 1'b1;
    while (!in_ready_o) begin
      if (n == WaitLimit) begin
        report_timeout("in_ready_o");
      end
      next_cycle();
      n++;
    end
    next_cycle();
    in_valid_i = 1'b0;
  endtask

  task automatic send_job(input elem_vec_t [ARRAY_DIM-1:0] x, input elem_vec_t w,
                          input elem_vec_t y);
    for (int r = 0; r < ARRAY_DIM; r++) begin
      load_beat(BEAT_X_ROW, IDX_W'(r), x[r]);
    end
    load_beat(BEAT_W_VEC, '0, w);
    load_beat(BEAT_Y_VEC, '0, y);
  endtask

  // Waits for z_valid_o and checks the job latency
  task automatic wait_z();
    int cycles;
    cycles = 0;
    while (!z_valid_o) begin
      if (cycles == WaitLimit) begin
        report_timeout("z_valid_o");
      end
      check_bit(in_ready_o, 1'b0, "in_ready_o while job runs");
      // Start pulse raises busy_o one cycle after the completing beat
      if (cycles > 0) begin
        check_bit(busy_o, 1'b1, "busy_o while job runs");
      end
      next_cycle();
      cycles++;
    end
    check_bit(cycles == Latency, 1'b1, "job latency in cycles");
  endtask

  task automatic take_z(input z_vec_t exp, input string what);
    check_z(z_o, exp, what);
    check_bit(busy_o, 1'b1, "busy_o before hand-off");
    z_ready_i = 1'b1;
    next_cycle();
    z_ready_i = 1'b0;
    check_bit(z_valid_o, 1'b0, "z_valid_o after hand-off");
    check_bit(busy_o, 1'b0, "busy_o after hand-off");
    check_bit(in_ready_o, 1'b1, "in_ready_o after hand-off");
  endtask

  task automatic test_reset_state();
    check_bit(in_ready_o, 1'b1, "in_ready_o after reset");
    check_bit(z_valid_o, 1'b0, "z_valid_o after reset");
    check_bit(busy_o, 1'b0, "busy_o after reset");
  endtask

  task automatic test_directed();
    load_beat(BEAT_X_ROW, 2'd0, '{8'sd1, -8'sd2, 8'sd3, -8'sd4});
    load_beat(BEAT_X_ROW, 2'd1, '{-8'sd5, 8'sd6, 8'sd0, 8'sd7});
    load_beat(BEAT_X_ROW, 2'd2, '{8'sd10, 8'sd10, -8'sd10, 8'sd1});
    load_beat(BEAT_X_ROW, 2'd3, '{-8'sd1, -8'sd1, -8'sd1, -8'sd1});
    load_beat(BEAT_W_VEC, 2'd0, '{8'sd2, -8'sd3, 8'sd4, 8'sd5});
    load_beat(BEAT_Y_VEC, 2'd0, '{-8'sd20, 8'sd0, 8'sd15, 8'sd100});
    wait_z();
    take_z(expected_z(x_m, w_m, y_m), "directed job");
  endtask

  task automatic test_order_overwrite();
    load_beat(BEAT_Y_VEC, 2'd0, '{8'sd3, -8'sd7, 8'sd9, -8'sd1});
    load_beat(BEAT_W_VEC, 2'd0, '{-8'sd6, 8'sd2, 8'sd1, -8'sd3});
    load_beat(BEAT_X_ROW, 2'd3, '{8'sd4, 8'sd4, -8'sd4, 8'sd4});
    load_beat(BEAT_X_ROW, 2'd2, '{8'sd9, -8'sd8, 8'sd7, -8'sd6});
    load_beat(BEAT_X_ROW, 2'd1, '{-8'sd2, 8'sd5, 8'sd11, 8'sd0});
    // Row 2 again, the later value must be used
    load_beat(BEAT_X_ROW, 2'd2, '{-8'sd12, 8'sd13, -8'sd14, 8'sd15});
    // Row 0 still missing, nothing may start
    for (int i = 0; i < 20; i++) begin
      check_bit(z_valid_o, 1'b0, "z_valid_o with incomplete set");
      check_bit(busy_o, 1'b0, "busy_o with incomplete set");
      check_bit(in_ready_o, 1'b1, "in_ready_o with incomplete set");
      next_cycle();
    end
    load_beat(BEAT_X_ROW, 2'd0, '{8'sd1, 8'sd2, 8'sd3, 8'sd4});
    wait_z();
    take_z(expected_z(x_m, w_m, y_m), "reordered job");
  endtask

  task automatic test_back_pressure();
    z_vec_t held;
    send_job('{rand_vec(), rand_vec(), rand_vec(), rand_vec()}, rand_vec(), rand_vec());
    wait_z();
    held = z_o;
    check_z(held, expected_z(x_m, w_m, y_m), "stalled job");
    for (int i = 0; i < 10; i++) begin
      next_cycle();
      check_bit(z_valid_o, 1'b1, "z_valid_o under back-pressure");
      check_z(z_o, held, "z_o under back-pressure");
      check_bit(in_ready_o, 1'b0, "in_ready_o under back-pressure");
      check_bit(busy_o, 1'b1, "busy_o under back-pressure");
    end
    take_z(held, "stalled job hand-off");
  endtask

  task automatic test_random_jobs();
    elem_vec_t [ARRAY_DIM-1:0] x;
    elem_vec_t                 w;
    elem_vec_t                 y;
    for (int j = 0; j < 20; j++) begin
      if (j < 2) begin
        // Extremes first, all most negative then all most positive
        w = {ARRAY_DIM{(j == 0) ? 8'h80 : 8'h7f}};
        x = {ARRAY_DIM{w}};
        y = w;
      end else begin
        for (int r = 0; r < ARRAY_DIM; r++) begin
          x[r] = rand_vec();
        end
        w = rand_vec();
        y = rand_vec();
      end
      send_job(x, w, y);
      wait_z();
      take_z(expected_z(x_m, w_m, y_m), "random job");
    end
  endtask

  initial begin
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    in_beat_i  = '0;
    z_ready_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    #10;
    rst_i = 1'b0;
    test_reset_state();
    test_directed();
    test_order_overwrite();
    test_back_pressure();
    test_random_jobs();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* all.f */
mm_pkg.sv
mm_load_buffer.sv
mm_pe_row.sv
mm_engine.sv
mm_z_buffer.sv
mm_top.sv
tb_mm.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_mm
FILELIST := all.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
